/* logic/sensio_pkg.sv */
/*
 * Shared definitions for the parallel sensor port:
 * local register offsets, control-word field positions,
 * status packet address and the command/pixel types
 */
`default_nettype none

package sensio_pkg;

    // local offsets within the 3-bit command address
    localparam logic [2:0] SENSIO_CTRL   = 3'h0; // sensor control bits
    localparam logic [2:0] SENSIO_STATUS = 3'h1; // status request, data[1:0] is seq
    localparam logic [2:0] SENSIO_WIDTH  = 3'h3; // line width, 0 means use HACT as is

    // two-bit fields in the control word: 3 sets, 2 clears, else keep
    localparam int SENS_CTRL_MRST = 0; // bits 1:0
    localparam int SENS_CTRL_ARST = 2; // bits 3:2
    localparam int SENS_CTRL_ARO  = 4; // bits 5:4

    localparam logic [7:0] SENSIO_STATUS_REG = 8'h21; // first byte of status packet

    localparam int CMD_BYTES = 6; // AL, AH, D0..D3

    typedef logic [2:0]  sens_cmd_addr_t; // local register address
    typedef logic [31:0] sens_cmd_data_t; // command payload
    typedef logic [11:0] pxd_t;           // one pixel sample

endpackage

`default_nettype wire

/* logic/sens_cmd_deser.sv */
/*
 * Byte-serial command deserializer.
 * Six bytes per command (address low/high, data 0..3),
 * address match under mask, single-cycle write strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module sens_cmd_deser import sensio_pkg::*; #(
    parameter logic [15:0] SENSIO_ADDR      = 16'h330,
    parameter logic [15:0] SENSIO_ADDR_MASK = 16'h7f8
) (
    input  wire logic           mclk,
    input  wire logic           async_prst_with_sens_mrst,
    input  wire logic [7:0]     cmd_ad_i,   // byte stream
    input  wire logic           cmd_stb_i,  // with first byte
    output logic                cmd_we_o,   // one cycle after last byte
    output sens_cmd_addr_t      cmd_a_o,
    output sens_cmd_data_t      cmd_data_o
);

    logic [CMD_BYTES-1:1] byte_sel; // one-hot, bit n high while byte n is on the bus
    logic [15:0]          addr_r;   // full 16-bit command address
    logic                 addr_match;

    assign addr_match = (addr_r & SENSIO_ADDR_MASK) == (SENSIO_ADDR & SENSIO_ADDR_MASK);
    assign cmd_a_o    = addr_r[$bits(sens_cmd_addr_t)-1:0]; // low bits select register

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            byte_sel <= '0;
            cmd_we_o <= 1'b0;
        end else begin
            byte_sel <= {byte_sel[CMD_BYTES-2:1], cmd_stb_i}; // walk through the bytes
            cmd_we_o <= byte_sel[CMD_BYTES-1] && addr_match;  // address already complete
        end
    end

    // payload shift, no reset needed
    always_ff @(posedge mclk) begin
        if (cmd_stb_i) begin
            addr_r[7:0] <= cmd_ad_i;  // address low
        end
        if (byte_sel[1]) begin
            addr_r[15:8] <= cmd_ad_i; // address high
        end
        if (|byte_sel[CMD_BYTES-1:2]) begin
            cmd_data_o <= {cmd_ad_i, cmd_data_o[31:8]}; // D0 ends up in low byte
        end
    end

    // a new command must not overlap the one being collected
    a_no_stb_overlap: assert property (
        @(posedge mclk) disable iff (async_prst_with_sens_mrst)
        cmd_stb_i |-> !(|byte_sel)
    );

endmodule

`default_nettype wire

/* logic/sens_ctrl_regs.sv */
/*
 * Control register file of the sensor port.
 * Decodes command writes into MRST/ARST/ARO set/clear fields,
 * the regenerated line width and the status request strobe.
 * ARO follows the inverted trigger in trigger mode.
 */
`timescale 1ns/1ps
`default_nettype none

module sens_ctrl_regs import sensio_pkg::*; #(
    parameter int LINE_WIDTH_BITS = 16
) (
    input  wire logic                       mclk,
    input  wire logic                       async_prst_with_sens_mrst,
    input  wire logic                       cmd_we_i,
    input  wire sens_cmd_addr_t             cmd_a_i,
    input  wire sens_cmd_data_t             cmd_data_i,
    input  wire logic                       trigger_mode_i, // 0 - free running
    input  wire logic                       trig_i,
    output logic                            mrst_o,
    output logic                            arst_o,
    output logic                            aro_o,
    output logic [LINE_WIDTH_BITS-1:0]      line_width_m1_o,
    output logic                            line_width_internal_o, // 1 - pass HACT through
    output logic                            set_status_o,
    output logic [1:0]                      status_seq_o
);

    sens_cmd_data_t data_r;       // registered command word
    logic           set_ctrl_r;
    logic           set_status_r;
    logic [1:0]     set_width_r;  // two stages for the subtract
    logic           aro_soft;     // ARO as programmed

    assign aro_o = trigger_mode_i ? ~trig_i : aro_soft;

    always_ff @(posedge mclk) begin
        if (cmd_we_i) begin
            data_r <= cmd_data_i;
        end
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            set_ctrl_r            <= 1'b0;
            set_status_r          <= 1'b0;
            set_width_r           <= '0;
            mrst_o                <= 1'b0;
            arst_o                <= 1'b0;
            aro_soft              <= 1'b0;
            set_status_o          <= 1'b0;
            status_seq_o          <= '0;
            line_width_m1_o       <= '0;
            line_width_internal_o <= 1'b1; // width 0, HACT passed through
        end else begin
            set_ctrl_r   <= cmd_we_i && (cmd_a_i == SENSIO_CTRL);
            set_status_r <= cmd_we_i && (cmd_a_i == SENSIO_STATUS);
            set_width_r  <= {set_width_r[0], cmd_we_i && (cmd_a_i == SENSIO_WIDTH)};

            if (set_ctrl_r && data_r[SENS_CTRL_MRST + 1]) begin
                mrst_o <= data_r[SENS_CTRL_MRST];
            end
            if (set_ctrl_r && data_r[SENS_CTRL_ARST + 1]) begin
                arst_o <= data_r[SENS_CTRL_ARST];
            end
            if (set_ctrl_r && data_r[SENS_CTRL_ARO + 1]) begin
                aro_soft <= data_r[SENS_CTRL_ARO];
            end

            set_status_o <= set_status_r; // to alive/status logic
            if (set_status_r) begin
                status_seq_o <= data_r[1:0];
            end

            if (set_width_r[1]) begin
                line_width_m1_o       <= data_r[LINE_WIDTH_BITS-1:0] - 1'b1;
                line_width_internal_o <= ~(|data_r[LINE_WIDTH_BITS-1:0]); // width of 0
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sens_hact_regen.sv */
/*
 * Sensor bus input stage and HACT regeneration.
 * Fixed-width HACT from a down counter, or sampled HACT when width is 0.
 * Pixels and VACT are aligned to the HACT output (2 cycles).
 * Rising-edge strobes for the alive flags.
 */
`timescale 1ns/1ps
`default_nettype none

module sens_hact_regen import sensio_pkg::*; #(
    parameter int LINE_WIDTH_BITS = 16
) (
    input  wire logic                       mclk,
    input  wire logic                       async_prst_with_sens_mrst,
    input  wire pxd_t                       pxd_i,
    input  wire logic                       vact_i,
    input  wire logic                       hact_i,
    input  wire logic [LINE_WIDTH_BITS-1:0] line_width_m1_i,
    input  wire logic                       line_width_internal_i,
    output pxd_t                            pxd_o,
    output logic                            vact_o,
    output logic                            hact_o,
    output logic                            vact_rise_o,
    output logic                            hact_ext_rise_o,
    output logic                            hact_rise_o
);

    pxd_t                       pxd_s;     // sampled pixel bus
    logic                       vact_s;
    logic                       hact_s;
    logic                       hact_s_d;  // previous sampled hact
    logic                       hact_o_d;
    logic [LINE_WIDTH_BITS-1:0] hact_cntr; // remaining cycles of the line

    assign hact_ext_rise_o = hact_s && !hact_s_d;
    assign vact_rise_o     = vact_s && !vact_o;  // vact_o is vact_s one cycle later
    assign hact_rise_o     = hact_o && !hact_o_d;

    always_ff @(posedge mclk) begin
        pxd_s <= pxd_i;
        pxd_o <= pxd_s; // aligned with hact_o
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            vact_s    <= 1'b0;
            hact_s    <= 1'b0;
            hact_s_d  <= 1'b0;
            vact_o    <= 1'b0;
            hact_o    <= 1'b0;
            hact_o_d  <= 1'b0;
            hact_cntr <= '0;
        end else begin
            vact_s   <= vact_i;
            hact_s   <= hact_i;
            hact_s_d <= hact_s;
            vact_o   <= vact_s;
            hact_o_d <= hact_o;

            if (hact_ext_rise_o) begin
                hact_o <= 1'b1;
            end else if (line_width_internal_i ? !hact_s : (hact_cntr == '0)) begin
                hact_o <= 1'b0; // input fell, or line done
            end

            if (hact_ext_rise_o) begin
                hact_cntr <= line_width_m1_i;
            end else if (hact_o && !line_width_internal_i && (hact_cntr != '0)) begin
                hact_cntr <= hact_cntr - 1'b1;
            end
        end
    end

    // running fixed-width line stays within the programmed width, no wrap below 0
    a_cntr_no_wrap: assert property (
        @(posedge mclk) disable iff (async_prst_with_sens_mrst)
        hact_o && !line_width_internal_i |-> (hact_cntr <= line_width_m1_i)
    );

endmodule

`default_nettype wire

/* logic/sens_status_gen.sv */
/*
 * Alive flags, toggle-bit accumulator and status packet sender.
 * A status write clears the flags and raises the request;
 * after start the packet is address, control/alive byte, toggle byte.
 */
`timescale 1ns/1ps
`default_nettype none

module sens_status_gen import sensio_pkg::*; #(
    parameter int STATUS_ALIVE_WIDTH = 4
) (
    input  wire logic                          mclk,
    input  wire logic                          async_prst_with_sens_mrst,
    input  wire logic                          set_status_i,
    input  wire logic [1:0]                    status_seq_i,
    input  wire logic                          mrst_i,
    input  wire logic                          arst_i,
    input  wire logic                          aro_i,
    input  wire logic                          vact_rise_i,
    input  wire logic                          hact_ext_rise_i,
    input  wire logic                          hact_rise_i,
    input  wire logic [STATUS_ALIVE_WIDTH-1:0] status_alive_1cyc_i, // external toggles
    input  wire logic                          status_start_i,      // ack of address byte
    output logic                               status_rq_o,
    output logic [7:0]                         status_ad_o
);

    logic                          vact_alive;
    logic                          hact_ext_alive;
    logic                          hact_alive;
    logic [STATUS_ALIVE_WIDTH-1:0] alive_acc; // ORed toggle bits
    logic [1:0]                    step;      // bytes 1 and 2 of the packet

    always_comb begin
        if (status_start_i) begin
            status_ad_o = SENSIO_STATUS_REG;
        end else if (step[0]) begin
            status_ad_o = {status_seq_i, vact_alive, hact_ext_alive, hact_alive,
                           mrst_i, arst_i, aro_i};
        end else if (step[1]) begin
            status_ad_o = 8'(alive_acc);
        end else begin
            status_ad_o = 8'h00; // idle bus
        end
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            vact_alive     <= 1'b0;
            hact_ext_alive <= 1'b0;
            hact_alive     <= 1'b0;
            alive_acc      <= '0;
            status_rq_o    <= 1'b0;
            step           <= '0;
        end else begin
            if (set_status_i) begin
                vact_alive     <= 1'b0;
                hact_ext_alive <= 1'b0;
                hact_alive     <= 1'b0;
                alive_acc      <= '0;
            end else begin
                vact_alive     <= vact_alive || vact_rise_i;
                hact_ext_alive <= hact_ext_alive || hact_ext_rise_i;
                hact_alive     <= hact_alive || hact_rise_i;
                alive_acc      <= alive_acc | status_alive_1cyc_i;
            end

            if (set_status_i) begin
                status_rq_o <= 1'b1; // new write restarts a pending request
            end else if (status_start_i) begin
                status_rq_o <= 1'b0;
            end

            step <= {step[0], status_start_i};
        end
    end

    // downstream only starts a packet that was requested
    a_start_with_rq: assert property (
        @(posedge mclk) disable iff (async_prst_with_sens_mrst)
        status_start_i |-> status_rq_o
    );

endmodule

`default_nettype wire

/* logic/sens_parallel12.sv */
/*
 * 12-bit parallel sensor port, control and timing core.
 * Command deserializer -> control registers -> HACT regeneration
 * and status packet generation, all on mclk.
 */
`timescale 1ns/1ps
`default_nettype none

module sens_parallel12 import sensio_pkg::*; #(
    parameter logic [15:0] SENSIO_ADDR        = 16'h330,
    parameter logic [15:0] SENSIO_ADDR_MASK   = 16'h7f8,
    parameter int          LINE_WIDTH_BITS    = 16,
    parameter int          STATUS_ALIVE_WIDTH = 4
) (
    input  wire logic                          mclk,
    input  wire logic                          async_prst_with_sens_mrst,
    input  wire logic [7:0]                    cmd_ad_i,
    input  wire logic                          cmd_stb_i,
    input  wire logic                          trigger_mode_i,
    input  wire logic                          trig_i,
    input  wire pxd_t                          pxd_i,
    input  wire logic                          vact_i,
    input  wire logic                          hact_i,
    input  wire logic [STATUS_ALIVE_WIDTH-1:0] status_alive_1cyc_i,
    input  wire logic                          status_start_i,
    output pxd_t                               pxd_o,
    output logic                               vact_o,
    output logic                               hact_o,
    output logic                               mrst_o,
    output logic                               arst_o,
    output logic                               aro_o,
    output logic                               status_rq_o,
    output logic [7:0]                         status_ad_o
);

    logic                       cmd_we;
    sens_cmd_addr_t             cmd_a;
    sens_cmd_data_t             cmd_data;
    logic [LINE_WIDTH_BITS-1:0] line_width_m1;
    logic                       line_width_internal;
    logic                       set_status;
    logic [1:0]                 status_seq;
    logic                       vact_rise;
    logic                       hact_ext_rise;
    logic                       hact_rise;

    sens_cmd_deser #(
        .SENSIO_ADDR      (SENSIO_ADDR),
        .SENSIO_ADDR_MASK (SENSIO_ADDR_MASK)
    ) cmd_deser_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .cmd_we_o                  (cmd_we),
        .cmd_a_o                   (cmd_a),
        .cmd_data_o                (cmd_data)
    );

    sens_ctrl_regs #(
        .LINE_WIDTH_BITS (LINE_WIDTH_BITS)
    ) ctrl_regs_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_we_i                  (cmd_we),
        .cmd_a_i                   (cmd_a),
        .cmd_data_i                (cmd_data),
        .trigger_mode_i            (trigger_mode_i),
        .trig_i                    (trig_i),
        .mrst_o                    (mrst_o),
        .arst_o                    (arst_o),
        .aro_o                     (aro_o),
        .line_width_m1_o           (line_width_m1),
        .line_width_internal_o     (line_width_internal),
        .set_status_o              (set_status),
        .status_seq_o              (status_seq)
    );

    sens_hact_regen #(
        .LINE_WIDTH_BITS (LINE_WIDTH_BITS)
    ) hact_regen_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .pxd_i                     (pxd_i),
        .vact_i                    (vact_i),
        .hact_i                    (hact_i),
        .line_width_m1_i           (line_width_m1),
        .line_width_internal_i     (line_width_internal),
        .pxd_o                     (pxd_o),
        .vact_o                    (vact_o),
        .hact_o                    (hact_o),
        .vact_rise_o               (vact_rise),
        .hact_ext_rise_o           (hact_ext_rise),
        .hact_rise_o               (hact_rise)
    );

    sens_status_gen #(
        .STATUS_ALIVE_WIDTH (STATUS_ALIVE_WIDTH)
    ) status_gen_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .set_status_i              (set_status),
        .status_seq_i              (status_seq),
        .mrst_i                    (mrst_o),
        .arst_i                    (arst_o),
        .aro_i                     (aro_o),
        .vact_rise_i               (vact_rise),
        .hact_ext_rise_i           (hact_ext_rise),
        .hact_rise_i               (hact_rise),
        .status_alive_1cyc_i       (status_alive_1cyc_i),
        .status_start_i            (status_start_i),
        .status_rq_o               (status_rq_o),
        .status_ad_o               (status_ad_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_sens_parallel12.sv */
/*
 * Testbench for the 12-bit parallel sensor port core.
 * Reads command, line, status and trigger records from the stimulus file,
 * drives the DUT and checks control bits, pixel/VACT alignment, HACT and status packets
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sens_parallel12 import sensio_pkg::*; ();

    localparam int          CLK_PERIOD  = 20;
    localparam int          MAX_RECORDS = 64;
    localparam int          RQ_TIMEOUT  = 50;       // cycles to wait for status request
    localparam logic [15:0] ADDR        = 16'h330;
    localparam logic [15:0] ADDR_MASK   = 16'h7f8;

    logic        mclk;
    logic        rst;
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic        trigger_mode;
    logic        trig;
    pxd_t        pxd;
    logic        vact;
    logic        hact;
    logic [3:0]  alive_1cyc;
    logic        status_start;
    pxd_t        pxd_out;
    logic        vact_out;
    logic        hact_out;
    logic        mrst_out;
    logic        arst_out;
    logic        aro_out;
    logic        status_rq;
    logic [7:0]  status_ad;

    logic [31:0] stim [0:4*MAX_RECORDS-1]; // type, a, b, c per record
    int          rec_count;
    int          test_errors;                // errors of the running test
    int          total_errors;
    int          failed_tests;
    string       test_name;
    logic        exp_mrst;                   // control register model
    logic        exp_arst;
    logic        exp_aro_soft;

    sens_parallel12 #(
        .SENSIO_ADDR        (ADDR),
        .SENSIO_ADDR_MASK   (ADDR_MASK),
        .LINE_WIDTH_BITS    (16),
        .STATUS_ALIVE_WIDTH (4)
    ) DUT (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (rst),
        .cmd_ad_i                  (cmd_ad),
        .cmd_stb_i                 (cmd_stb),
        .trigger_mode_i            (trigger_mode),
        .trig_i                    (trig),
        .pxd_i                     (pxd),
        .vact_i                    (vact),
        .hact_i                    (hact),
        .status_alive_1cyc_i       (alive_1cyc),
        .status_start_i            (status_start),
        .pxd_o                     (pxd_out),
        .vact_o                    (vact_out),
        .hact_o                    (hact_out),
        .mrst_o                    (mrst_out),
        .arst_o                    (arst_out),
        .aro_o                     (aro_out),
        .status_rq_o               (status_rq),
        .status_ad_o               (status_ad)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch %s: expected %0h, actual %0h", what, exp, act);
            test_errors++;
        end
    endtask

    // two-bit field: 3 sets, 2 clears, anything else keeps
    function automatic logic apply_field(input logic old, input logic [1:0] field);
        case (field)
            2'b11:   return 1'b1;
            2'b10:   return 1'b0;
            default: return old;
        endcase
    endfunction

    task automatic check_ctrl(input string what);
        logic exp_aro;
        exp_aro = trigger_mode ? ~trig : exp_aro_soft; // trigger overrides soft ARO
        check_val({what, " mrst"}, 32'(exp_mrst), 32'(mrst_out));
        check_val({what, " arst"}, 32'(exp_arst), 32'(arst_out));
        check_val({what, " aro"}, 32'(exp_aro), 32'(aro_out));
    endtask

    // six bytes on consecutive cycles, strobe with the first
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] all_bytes;
        all_bytes = {data, addr};
        for (int i = 0; i < CMD_BYTES; i++) begin
            @(posedge mclk);
            cmd_stb <= (i == 0);
            cmd_ad  <= all_bytes[8*i +: 8];
        end
        @(posedge mclk);
        cmd_ad <= 8'h00;
    endtask

    task automatic run_command(input logic [15:0] addr, input logic [31:0] data);
        logic is_ctrl;
        is_ctrl   = ((addr & ADDR_MASK) == (ADDR & ADDR_MASK)) && (addr[2:0] == SENSIO_CTRL);
        test_name = $sformatf("command %04h <- %08h", addr, data);
        send_cmd(addr, data);
        @(posedge mclk);
        @(negedge mclk);
        check_ctrl({test_name, " (7 cycles)"}); // still the old values
        if (is_ctrl) begin
            exp_mrst     = apply_field(exp_mrst, data[SENS_CTRL_MRST +: 2]);
            exp_arst     = apply_field(exp_arst, data[SENS_CTRL_ARST +: 2]);
            exp_aro_soft = apply_field(exp_aro_soft, data[SENS_CTRL_ARO +: 2]);
        end
        @(posedge mclk);
        @(negedge mclk);
        check_ctrl({test_name, " (8 cycles)"});
    endtask

    task automatic run_line(input int hact_len, input int width);
        pxd_t pxd_hist[$];
        logic vact_hist[$];
        pxd_t new_pxd;
        logic new_vact;
        logic exp_hact;
        int   out_len;
        int   span;
        test_name = $sformatf("line length %0d width %0d", hact_len, width);
        out_len   = (width == 0) ? hact_len : width; // 0 passes HACT through
        span      = 2 + ((hact_len > out_len) ? hact_len : out_len) + 3;
        send_cmd({ADDR[15:3], SENSIO_WIDTH}, 32'(width));
        repeat (3) @(posedge mclk); // width in effect 9 cycles after strobe
        for (int k = 0; k < span; k++) begin
            new_pxd  = pxd_t'($urandom);
            new_vact = (k == 1) ? 1'b1 : 1'($urandom); // at least one VACT rise
            @(posedge mclk);
            hact <= (k < hact_len);
            pxd  <= new_pxd;
            vact <= new_vact;
            pxd_hist.push_back(new_pxd);
            vact_hist.push_back(new_vact);
            @(negedge mclk);
            exp_hact = (k >= 2) && (k < 2 + out_len);
            check_val($sformatf("%s hact cycle %0d", test_name, k), 32'(exp_hact), 32'(hact_out));
            if (k >= 2) begin
                check_val({test_name, " pxd"}, 32'(pxd_hist[k-2]), 32'(pxd_out));
                check_val({test_name, " vact"}, 32'(vact_hist[k-2]), 32'(vact_out));
            end
        end
        @(posedge mclk);
        vact <= 1'b0;
    endtask

    task automatic run_status(input logic [31:0] toggles, input logic [7:0] byte1,
                              input logic [7:0] byte2);
        int wait_cycles;
        test_name = $sformatf("status seq %0d", byte1[7:6]);
        for (int i = 0; i < 8; i++) begin
            @(posedge mclk);
            alive_1cyc <= toggles[4*i +: 4]; // one nibble per cycle
        end
        @(posedge mclk);
        alive_1cyc <= 4'h0;
        wait_cycles = 0;
        @(negedge mclk);
        while (!status_rq && wait_cycles < RQ_TIMEOUT) begin
            @(negedge mclk);
            wait_cycles++;
        end
        assert (status_rq) else begin
            $display("%s: status request did not rise within %0d cycles", test_name, RQ_TIMEOUT);
            test_errors++;
        end
        if (status_rq) begin
            @(posedge mclk);
            status_start <= 1'b1;
            @(negedge mclk);
            check_val({test_name, " byte 0"}, 32'h21, 32'(status_ad));
            @(posedge mclk);
            status_start <= 1'b0;
            @(negedge mclk);
            check_val({test_name, " byte 1"}, 32'(byte1), 32'(status_ad));
            check_val({test_name, " request"}, 32'h0, 32'(status_rq));
            @(posedge mclk);
            @(negedge mclk);
            check_val({test_name, " byte 2"}, 32'(byte2), 32'(status_ad));
            @(posedge mclk);
            @(negedge mclk);
            check_val({test_name, " idle"}, 32'h0, 32'(status_ad));
        end
    endtask

    task automatic run_trigger(input logic mode, input logic trig_v, input logic exp_aro);
        test_name = $sformatf("trigger mode %0d trig %0d", mode, trig_v);
        @(posedge mclk);
        trigger_mode <= mode;
        trig         <= trig_v;
        @(negedge mclk);
        check_val({test_name, " aro"}, 32'(exp_aro), 32'(aro_out));
        check_ctrl(test_name);
    endtask

    initial begin
        int n_rec;
        void'($urandom(32'hd2e9));
        rst          = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        trigger_mode = 1'b0;
        trig         = 1'b0;
        pxd          = '0;
        vact         = 1'b0;
        hact         = 1'b0;
        alive_1cyc   = 4'h0;
        status_start = 1'b0;
        exp_mrst     = 1'b0;
        exp_arst     = 1'b0;
        exp_aro_soft = 1'b0;
        total_errors = 0;
        failed_tests = 0;
        for (int i = 0; i < 4 * MAX_RECORDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("testbench/sens_stimulus.txt", stim);
        n_rec = 0;
        while (n_rec < MAX_RECORDS && stim[4*n_rec] != 0) begin
            n_rec++; // type 0 ends the list
        end
        rec_count = n_rec; // final count for the watchdog
        if (rec_count == 0) begin
            $display("no stimulus records were read");
            total_errors++;
        end
        repeat (8) @(posedge mclk);
        rst <= 1'b0;
        for (int r = 0; r < rec_count; r++) begin
            test_errors = 0;
            case (stim[4*r])
                1: run_command(stim[4*r+1][15:0], stim[4*r+2]);
                2: run_line(int'(stim[4*r+1]), int'(stim[4*r+2]));
                3: run_status(stim[4*r+1], stim[4*r+2][7:0], stim[4*r+3][7:0]);
                4: run_trigger(stim[4*r+1][0], stim[4*r+2][0], stim[4*r+3][0]);
                default: begin
                    test_name = "unknown record";
                    $display("record %0d has unknown type %0h", r, stim[4*r]);
                    test_errors++;
                end
            endcase
            $display("test %0d %s: %s", r, test_name, (test_errors == 0) ? "ok" : "FAILED");
            total_errors += test_errors;
            if (test_errors != 0) begin
                failed_tests++;
            end
        end
        $display("tests: %0d, failed: %0d, errors: %0d", rec_count, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // budget of 200 cycles per record
    initial begin
        wait (rec_count > 0);
        #(rec_count * 200 * CLK_PERIOD);
        $display("watchdog expired, tests did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sens_stimulus.txt */
// columns: type a b c, 1 = command (address, data), 2 = line (hact length, width)
// 3 = status (toggle nibbles, byte 1, byte 2), 4 = trigger (mode, trig, aro), 0 = end
1 0330 00000003 0
1 0330 0000003c 0
1 0337 00000002 0
1 0340 00000002 0
1 8330 00000002 0
1 0330 00000021 0
1 0330 0000000b 0
4 1 0 1
4 1 1 0
4 0 1 0
1 0330 00000030 0
4 0 0 1
4 1 1 0
4 1 0 1
4 0 0 1
1 0331 00000001 0
2 3 8 0
2 5 0 0
2 9 4 0
2 4 1 0
2 6 0 0
3 00000041 7d 05
1 0331 00000002 0
3 00000000 85 00
1 0331 00000003 0
1 0331 00000000 0
3 00000082 05 0a
1 0330 0000002a 0
1 0331 00000003 0
3 00000000 c0 00
0 0 0 0

/* tb.f */
logic/sensio_pkg.sv
logic/sens_cmd_deser.sv
logic/sens_ctrl_regs.sv
logic/sens_hact_regen.sv
logic/sens_status_gen.sv
logic/sens_parallel12.sv
testbench/tb_sens_parallel12.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the sensor port testbench with Verilator
# the run passes only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_sens_parallel12 -Mdir obj_dir \
    && ./obj_dir/Vtb_sens_parallel12 > sim.log \
    ; cat sim.log 2> /dev/null \
    ; grep -qx "Done: no errors" sim.log \
    || { echo "simulation did not pass"; exit 1; }
